/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = chol_tb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* list.f */
+incdir+include
source/chol_pkg.sv
source/chol_sqrt.sv
source/chol_div.sv
source/chol_update.sv
source/chol_seq.sv
source/chol_top.sv
tb/chol_tb.sv

/* source/chol_div.sv */
`default_nettype none

module chol_div (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::q16_t dividend,
    input  chol_pkg::q16_t divisor,
    output logic           done,
    output chol_pkg::q16_t quotient
);
    import chol_pkg::*;

    localparam int NBITS = Q_WIDTH + FRAC_BITS;  // Dividend magnitude after the shift

    logic [NBITS-1:0]   num_q;
    logic [Q_WIDTH-1:0] den_q;
    logic [Q_WIDTH:0]   rem_q;
    logic [NBITS-1:0]   quo_q;
    logic               neg_q;
    logic [5:0]         cnt_q;
    logic               run_q;
    logic [Q_WIDTH:0]   rem_sh;
    logic [Q_WIDTH-1:0] dividend_mag;
    logic [Q_WIDTH-1:0] divisor_mag;

    always_comb begin
        dividend_mag = dividend[Q_WIDTH-1] ? -dividend : dividend;
        divisor_mag  = divisor[Q_WIDTH-1] ? -divisor : divisor;
        rem_sh       = {rem_q[Q_WIDTH-1:0], num_q[NBITS-1]};
    end

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            done  <= 1'b0;
            cnt_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 6'd1;
                if (cnt_q == 6'(NBITS - 1)) begin
                    run_q <= 1'b0;
                    done  <= 1'b1;
                end
            end
        end
    end

    // Restoring division on magnitudes
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            num_q <= {dividend_mag, {FRAC_BITS{1'b0}}};
            den_q <= divisor_mag;
            neg_q <= dividend[Q_WIDTH-1] ^ divisor[Q_WIDTH-1];
            rem_q <= '0;
            quo_q <= '0;
        end else if (run_q) begin
            num_q <= num_q << 1;
            if (rem_sh >= {1'b0, den_q}) begin
                rem_q <= rem_sh - {1'b0, den_q};
                quo_q <= {quo_q[NBITS-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh;
                quo_q <= {quo_q[NBITS-2:0], 1'b0};
            end
        end
    end

    // Truncation toward zero, sign applied last
    assign quotient = neg_q ? q16_t'(-quo_q[Q_WIDTH-1:0]) : q16_t'(quo_q[Q_WIDTH-1:0]);

    // The divisor is a freshly computed root
    a_divisor_nonzero: assert property (@(posedge clk) disable iff (rst)
        start |-> divisor != '0);

endmodule

`default_nettype wire

/* source/chol_pkg.sv */
`default_nettype none

package chol_pkg;

    // Sizes
    // --------------------
    localparam int N         = 5;
    localparam int NUM_ELEM  = N * (N + 1) / 2;   // Lower triangle incl. diagonal
    localparam int FRAC_BITS = 16;
    localparam int Q_WIDTH   = 32;
    localparam int ACC_WIDTH = 64;

    // Fixed unit latencies, start to done
    // --------------------
    localparam int SQRT_CYCLES = 25;              // 24 root bits plus one
    localparam int DIV_CYCLES  = 49;              // 48 quotient bits plus one

    // Types
    // --------------------
    typedef logic signed [Q_WIDTH-1:0]   q16_t;   // Q16.16
    typedef logic signed [ACC_WIDTH-1:0] acc_t;   // Q32.32 product sum

    // Element (i,j), i >= j, 1-based, at index i(i-1)/2 + j - 1
    typedef q16_t [NUM_ELEM-1:0] tri_mat_t;

    // Lanes below the diagonal, lane 0 is the row right under it
    typedef q16_t [N-2:0] col_vec_t;

    typedef logic [N-2:0] lane_mask_t;

    // Position of element (i,j) in a tri_mat_t, 1-based
    function automatic int tri_index(input int i, input int j);
        return i * (i - 1) / 2 + j - 1;
    endfunction

endpackage

`default_nettype wire

/* source/chol_seq.sv */
`default_nettype none

module chol_seq (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 a_valid,
    output logic                 busy,
    output logic                 l_valid,
    output chol_pkg::tri_mat_t   l,
    output logic                 load,
    output logic                 update,
    output logic [2:0]           col,
    input  chol_pkg::q16_t       res_diag,
    input  chol_pkg::col_vec_t   res_below,
    output logic                 sqrt_start,
    input  logic                 sqrt_done,
    input  chol_pkg::q16_t       sqrt_root,
    output chol_pkg::q16_t       sqrt_radicand,
    output chol_pkg::lane_mask_t div_start,
    output chol_pkg::q16_t       divisor,
    output chol_pkg::col_vec_t   dividends,
    input  logic                 div_done,
    input  chol_pkg::col_vec_t   quotients,
    output chol_pkg::q16_t       l_diag,
    output chol_pkg::col_vec_t   l_col
);
    import chol_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ROOT,
        ST_DIVIDE,
        ST_UPDATE,
        ST_FINISH
    } state_t;

    state_t state;

    // Lanes still inside the matrix for column k, 0-based
    function automatic lane_mask_t lanes_for(input int k);
        lane_mask_t mask;
        for (int m = 0; m < N - 1; m++) begin
            mask[m] = (m < N - 1 - k);
        end
        return mask;
    endfunction

    assign busy          = (state != ST_IDLE);
    assign load          = a_valid && (state == ST_IDLE);  // Update unit latches A here
    assign sqrt_radicand = res_diag;
    assign dividends     = res_below;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            col        <= '0;
            l          <= '0;
            l_valid    <= 1'b0;
            update     <= 1'b0;
            sqrt_start <= 1'b0;
            div_start  <= '0;
        end else begin
            l_valid    <= 1'b0;
            update     <= 1'b0;
            sqrt_start <= 1'b0;
            div_start  <= '0;
            case (state)
                ST_IDLE: begin
                    if (a_valid) begin
                        state      <= ST_ROOT;
                        col        <= '0;
                        l          <= '0;
                        sqrt_start <= 1'b1;
                    end
                end
                ST_ROOT: begin
                    if (sqrt_done) begin
                        for (int kk = 0; kk < N; kk++) begin
                            if (int'(col) == kk) begin
                                l[tri_index(kk + 1, kk + 1)] <= sqrt_root;
                            end
                        end
                        if (col == 3'(N - 1)) begin
                            state   <= ST_FINISH;
                            l_valid <= 1'b1;
                        end else begin
                            state     <= ST_DIVIDE;
                            div_start <= lanes_for(int'(col));
                        end
                    end
                end
                ST_DIVIDE: begin
                    if (div_done) begin         // Lane 0 stands for all lanes
                        for (int kk = 0; kk < N - 1; kk++) begin
                            if (int'(col) == kk) begin
                                for (int m = 0; m < N - 1 - kk; m++) begin
                                    l[tri_index(kk + 2 + m, kk + 1)] <= quotients[m];
                                end
                            end
                        end
                        state  <= ST_UPDATE;
                        update <= 1'b1;
                    end
                end
                ST_UPDATE: begin
                    state      <= ST_ROOT;
                    col        <= col + 3'd1;
                    sqrt_start <= 1'b1;          // Sums settled this cycle
                end
                default: begin
                    state <= ST_IDLE;            // l_valid cycle
                end
            endcase
        end
    end

    // Column operands for the units
    // --------------------
    always_ff @(posedge clk) begin
        if (state == ST_ROOT && sqrt_done) begin
            divisor <= sqrt_root;
        end
        if (state == ST_DIVIDE && div_done) begin
            l_col  <= quotients;
            l_diag <= divisor;
        end
    end

    // One unit runs at a time and a start is never repeated back to back
    a_one_start: assert property (@(posedge clk) disable iff (rst)
        (sqrt_start || div_start != '0) |=> (!sqrt_start && div_start == '0));

    a_done_in_root: assert property (@(posedge clk) disable iff (rst)
        sqrt_done |-> state == ST_ROOT);

endmodule

`default_nettype wire

/* source/chol_sqrt.sv */
`default_nettype none

module chol_sqrt (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  chol_pkg::q16_t radicand,
    output logic           done,
    output chol_pkg::q16_t root
);
    import chol_pkg::*;

    localparam int RBITS = SQRT_CYCLES - 1;      // Result bits

    logic [2*RBITS-1:0] x_q;                     // Radicand, shifted out two bits at a time
    logic [RBITS+2:0]   rem_q;
    logic [RBITS-1:0]   root_q;
    logic [4:0]         cnt_q;
    logic               run_q;
    logic [RBITS+2:0]   rem_sh;
    logic [RBITS+2:0]   trial;

    always_comb begin
        rem_sh = {rem_q[RBITS:0], x_q[2*RBITS-1 -: 2]};
        trial  = {1'b0, root_q, 2'b01};          // 4*root + 1
    end

    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            done  <= 1'b0;
            cnt_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'(RBITS - 1)) begin
                    run_q <= 1'b0;
                    done  <= 1'b1;               // Last bit lands with done
                end
            end
        end
    end

    // Datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            x_q    <= {radicand, {FRAC_BITS{1'b0}}};
            rem_q  <= '0;
            root_q <= '0;
        end else if (run_q) begin
            x_q <= x_q << 2;
            if (rem_sh >= trial) begin
                rem_q  <= rem_sh - trial;
                root_q <= {root_q[RBITS-2:0], 1'b1};
            end else begin
                rem_q  <= rem_sh;
                root_q <= {root_q[RBITS-2:0], 1'b0};
            end
        end
    end

    assign root = q16_t'({{(Q_WIDTH-RBITS){1'b0}}, root_q});

    // Inputs are positive definite, so every residual on the diagonal is too
    a_radicand_pos: assert property (@(posedge clk) disable iff (rst)
        start |-> !radicand[Q_WIDTH-1]);

endmodule

`default_nettype wire

/* source/chol_top.sv */
`default_nettype none

module chol_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               a_valid,
    input  chol_pkg::tri_mat_t a,
    output logic               busy,
    output logic               l_valid,
    output chol_pkg::tri_mat_t l
);
    import chol_pkg::*;

    logic       load;
    logic       update;
    logic [2:0] col;
    q16_t       res_diag;
    col_vec_t   res_below;
    logic       sqrt_start;
    logic       sqrt_done;
    q16_t       sqrt_root;
    q16_t       sqrt_radicand;
    lane_mask_t div_start;
    q16_t       divisor;
    col_vec_t   dividends;
    lane_mask_t lane_done;
    col_vec_t   quotients;
    q16_t       l_diag;
    col_vec_t   l_col;

    chol_seq i_seq (
        .clk, .rst, .a_valid, .busy, .l_valid, .l,
        .load, .update, .col, .res_diag, .res_below,
        .sqrt_start, .sqrt_done, .sqrt_root, .sqrt_radicand,
        .div_start, .divisor, .dividends,
        .div_done (lane_done[0]),
        .quotients, .l_diag, .l_col
    );

    chol_update i_update (
        .clk, .rst, .load, .update, .a, .col, .l_col, .l_diag, .res_diag, .res_below
    );

    chol_sqrt i_sqrt (
        .clk, .rst,
        .start    (sqrt_start),
        .radicand (sqrt_radicand),
        .done     (sqrt_done),
        .root     (sqrt_root)
    );

    // Divider lanes share the divisor
    for (genvar m = 0; m < N - 1; m++) begin : g_div
        chol_div i_div (
            .clk, .rst,
            .start    (div_start[m]),
            .dividend (dividends[m]),
            .divisor  (divisor),
            .done     (lane_done[m]),
            .quotient (quotients[m])
        );
    end

    // Lane 0 is active in every column and ends with the others
    a_lanes_aligned: assert property (@(posedge clk) disable iff (rst)
        lane_done != '0 |-> lane_done[0]);

endmodule

`default_nettype wire

/* source/chol_update.sv */
`default_nettype none

module chol_update (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic               update,
    input  chol_pkg::tri_mat_t a,
    input  logic [2:0]         col,
    input  chol_pkg::col_vec_t l_col,
    input  chol_pkg::q16_t     l_diag,
    output chol_pkg::q16_t     res_diag,
    output chol_pkg::col_vec_t res_below
);
    import chol_pkg::*;

    localparam int NUM_ACC = NUM_ELEM - N;       // Ten trailing elements

    tri_mat_t a_q;
    acc_t     acc_q [NUM_ACC];
    q16_t     colv [N];                          // Finished column, full height

    // Accumulator slot of (i,j), 0-based, j >= 1
    function automatic int acc_index(input int i, input int j);
        return i * (i + 1) / 2 + j - (i + 1);
    endfunction

    // Bits 47..16 of the sum for (i,j), nothing for column 0
    function automatic q16_t trail(input int i, input int j);
        if (j == 0) begin
            return '0;
        end
        return acc_q[acc_index(i, j)][FRAC_BITS+Q_WIDTH-1:FRAC_BITS];
    endfunction

    always_comb begin
        for (int r = 0; r < N; r++) begin
            colv[r] = '0;
        end
        for (int kk = 0; kk < N; kk++) begin
            if (int'(col) == kk) begin
                colv[kk] = l_diag;
                for (int m = 0; m < N - 1 - kk; m++) begin
                    colv[kk+1+m] = l_col[m];
                end
            end
        end
    end

    // Stored A and trailing sums
    // --------------------
    always_ff @(posedge clk) begin
        if (load) begin
            a_q <= a;
            for (int s = 0; s < NUM_ACC; s++) begin
                acc_q[s] <= '0;                  // New matrix starts clean
            end
        end else if (update && !rst) begin
            for (int i = 1; i < N; i++) begin
                for (int j = 1; j <= i; j++) begin
                    if (j > int'(col)) begin
                        acc_q[acc_index(i, j)] <= acc_q[acc_index(i, j)]
                            + acc_t'(colv[i]) * acc_t'(colv[j]);
                    end
                end
            end
        end
    end

    // Residuals of column col
    // --------------------
    always_comb begin
        res_diag  = '0;
        res_below = '0;
        for (int kk = 0; kk < N; kk++) begin
            if (int'(col) == kk) begin
                res_diag = a_q[tri_index(kk + 1, kk + 1)] - trail(kk, kk);
                for (int m = 0; m < N - 1 - kk; m++) begin
                    res_below[m] = a_q[tri_index(kk + 2 + m, kk + 1)] - trail(kk + 1 + m, kk);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* include/chol_tb_model.svh */
`ifndef CHOL_TB_MODEL_SVH
`define CHOL_TB_MODEL_SVH

// Bit-exact model of the engine arithmetic
// --------------------
function automatic chol_pkg::q16_t model_sqrt(input chol_pkg::q16_t x);
    longint unsigned v;
    longint unsigned r;
    v = longint'(x) << chol_pkg::FRAC_BITS;
    r = 0;
    for (int b = 23; b >= 0; b--) begin
        if ((r + (64'd1 << b)) * (r + (64'd1 << b)) <= v) begin
            r = r + (64'd1 << b);
        end
    end
    return chol_pkg::q16_t'(r);
endfunction

function automatic chol_pkg::q16_t model_div(input chol_pkg::q16_t n, input chol_pkg::q16_t d);
    longint q;
    q = (longint'(n) * 65536) / longint'(d);     // Truncates toward zero
    return chol_pkg::q16_t'(q);
endfunction

function automatic chol_pkg::tri_mat_t model_chol(input chol_pkg::tri_mat_t a);
    chol_pkg::tri_mat_t l;
    longint acc [6][6];
    chol_pkg::q16_t res;
    l = '0;
    for (int i = 1; i <= 5; i++) begin
        for (int j = 1; j <= 5; j++) begin
            acc[i][j] = 0;
        end
    end
    for (int k = 1; k <= 5; k++) begin
        res = a[chol_pkg::tri_index(k, k)] - chol_pkg::q16_t'(acc[k][k] >>> 16);
        l[chol_pkg::tri_index(k, k)] = model_sqrt(res);
        for (int i = k + 1; i <= 5; i++) begin
            res = a[chol_pkg::tri_index(i, k)] - chol_pkg::q16_t'(acc[i][k] >>> 16);
            l[chol_pkg::tri_index(i, k)] = model_div(res, l[chol_pkg::tri_index(k, k)]);
        end
        for (int i = k + 1; i <= 5; i++) begin
            for (int j = k + 1; j <= i; j++) begin
                acc[i][j] += longint'(l[chol_pkg::tri_index(i, k)])
                           * longint'(l[chol_pkg::tri_index(j, k)]);
            end
        end
    end
    return l;
endfunction

// Checks
// --------------------
task automatic compare_mat(input chol_pkg::tri_mat_t exp, input chol_pkg::tri_mat_t got,
                           input string what);
    for (int e = 0; e < chol_pkg::NUM_ELEM; e++) begin
        if (exp[e] !== got[e]) begin
            $display("mismatch at %0t: %s element %0d expected %h got %h",
                     $time, what, e, exp[e], got[e]);
            $display("Testbench failed");
            $fatal(1);
        end
    end
endtask

task automatic compare_flag(input logic exp, input logic got, input string what);
    if (exp !== got) begin
        $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
        $display("Testbench failed");
        $fatal(1);
    end
endtask

`endif

/* tb/chol_tb.sv */
`default_nettype none

module chol_tb;
    import chol_pkg::*;

    `include "chol_tb_model.svh"

    logic     clk = 1'b0;
    logic     rst;
    logic     a_valid;
    tri_mat_t a;
    logic     busy;
    logic     l_valid;
    tri_mat_t l;

    tri_mat_t exp_q [$];                         // Expected L per accepted matrix
    tri_mat_t hold_l;
    logic     exp_busy;
    logic     have_result;
    int       cycle_cnt;
    int       accept_cycle;
    int       n_sent;
    int       n_pulses;
    int       exp_latency = 5 * (SQRT_CYCLES + 1) + 4 * (DIV_CYCLES + 2) + 1;

    chol_top i_dut (
        .clk, .rst, .a_valid, .a, .busy, .l_valid, .l
    );

    always #10 clk = ~clk;

    // Stimulus helpers
    // --------------------
    // A = B*B' + 4I from a lower triangular B with entries in [-1, 1)
    function automatic tri_mat_t make_spd(input bit ident);
        int       b [1:5][1:5];
        longint   s;
        tri_mat_t m;
        for (int i = 1; i <= N; i++) begin
            for (int j = 1; j <= N; j++) begin
                if (j > i) begin
                    b[i][j] = 0;
                end else if (ident) begin
                    b[i][j] = (i == j) ? 65536 : 0;
                end else begin
                    b[i][j] = int'($urandom % 131072) - 65536;
                end
            end
        end
        for (int i = 1; i <= N; i++) begin
            for (int j = 1; j <= i; j++) begin
                s = 0;
                for (int k = 1; k <= j; k++) begin
                    s += longint'(b[i][k]) * longint'(b[j][k]);
                end
                m[tri_index(i, j)] = q16_t'(s >>> FRAC_BITS);
                if (i == j) begin
                    m[tri_index(i, j)] += q16_t'(4 << FRAC_BITS);   // Diagonal shift
                end
            end
        end
        return m;
    endfunction

    function automatic tri_mat_t random_words();
        tri_mat_t m;
        for (int e = 0; e < NUM_ELEM; e++) begin
            m[e] = q16_t'($urandom);
        end
        return m;
    endfunction

    task automatic compare_count(input int exp, input int got, input string what);
        if (exp != got) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Offer one matrix and wait for its l_valid
    task automatic run_matrix(input tri_mat_t a_in, input bit noise);
        @(negedge clk);
        a       = a_in;
        a_valid = 1'b1;
        exp_q.push_back(model_chol(a_in));
        n_sent++;
        @(negedge clk);
        a_valid = 1'b0;
        while (l_valid !== 1'b1) begin
            if (noise) begin
                a_valid = ($urandom % 4) == 0;   // Must be ignored while busy
                a       = random_words();
            end
            @(negedge clk);
        end
        a_valid = 1'b0;
        repeat ($urandom % 4) @(negedge clk);     // Idle gap while L holds
    endtask

    // Monitor
    // --------------------
    always @(posedge clk) begin
        if (rst) begin
            exp_busy = 1'b0;
        end else begin
            cycle_cnt++;
            compare_flag(exp_busy, busy, "busy");
            if (!exp_busy) begin
                compare_flag(1'b0, l_valid, "l_valid while idle");
                if (have_result) begin
                    compare_mat(hold_l, l, "held L");
                end
                if (a_valid) begin
                    exp_busy     = 1'b1;
                    accept_cycle = cycle_cnt;
                end
            end else if (l_valid) begin
                if (exp_q.size() == 0) begin
                    $display("l_valid pulsed at %0t with no matrix pending", $time);
                    $display("Testbench failed");
                    $fatal(1);
                end else begin
                    hold_l = exp_q.pop_front();
                    compare_mat(hold_l, l, "L");
                    compare_count(exp_latency, cycle_cnt - accept_cycle, "latency");
                    have_result = 1'b1;
                    n_pulses++;
                    exp_busy    = 1'b0;
                end
            end
        end
    end

    // Main sequence
    // --------------------
    initial begin
        void'($urandom(57));
        rst          = 1'b1;
        a_valid      = 1'b0;
        a            = '0;
        hold_l       = '0;
        exp_busy     = 1'b0;
        have_result  = 1'b0;
        cycle_cnt    = 0;
        accept_cycle = 0;
        n_sent       = 0;
        n_pulses     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        compare_flag(1'b0, busy, "busy after reset");
        compare_flag(1'b0, l_valid, "l_valid after reset");
        compare_mat('0, l, "L after reset");

        run_matrix(make_spd(1'b1), 1'b0);        // 5I gives the root of 5 on the diagonal
        for (int t = 0; t < 30; t++) begin
            run_matrix(make_spd(1'b0), (t % 2) == 1);
        end
        repeat (5) @(negedge clk);

        if (n_pulses != n_sent) begin
            $display("mismatch at %0t: l_valid pulses expected %0d got %0d",
                     $time, n_sent, n_pulses);
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // Watchdog allows 40 matrices worth of cycles plus slack
    initial begin
        #(40 * (exp_latency + 10) * 20 + 2000);
        $display("Timeout: l_valid never arrived for the last accepted matrix");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
